// ==== common/soc_map_pkg.sv ====
package soc_map_pkg;

    // ========================================================================
    // Bus geometry
    // ========================================================================
    localparam int addr_w = 16;
    localparam int data_w = 32;

    // Scratch RAM, 1024 words from byte 0x0000
    localparam int ram_words = 1024;
    localparam int ram_addr_w = $clog2(ram_words);
    localparam logic [addr_w-1:0] ram_top = 16'h1000;

    // ========================================================================
    // Peripheral registers
    // ========================================================================
    // Last make code in bits 7:0
    localparam logic [addr_w-1:0] key_data_addr = 16'h2000;
    // Bit 0 is key valid
    localparam logic [addr_w-1:0] key_status_addr = 16'h2004;
    // Write sends bits 7:0
    localparam logic [addr_w-1:0] tx_data_addr = 16'h2010;
    // Bit 0 is transmitter busy
    localparam logic [addr_w-1:0] tx_status_addr = 16'h2014;
    // Read pending flag, any write clears it
    localparam logic [addr_w-1:0] irq_addr = 16'h2020;

    // Decoder targets, tgt_none acks and reads zero
    typedef enum logic [2:0] {
        tgt_ram,
        tgt_key_data,
        tgt_key_status,
        tgt_tx_data,
        tgt_tx_status,
        tgt_irq,
        tgt_none
    } bus_target_t;

endpackage

// ==== common/periph_pkg.sv ====
package periph_pkg;

    // ========================================================================
    // PS/2 keyboard framing
    // ========================================================================
    // Start, 8 data, odd parity, stop
    localparam int ps2_frame_bits = 11;
    localparam int ps2_cnt_w = $clog2(ps2_frame_bits);

    // Prefix sent ahead of a key release
    localparam logic [7:0] ps2_break_code = 8'hF0;

    // ========================================================================
    // Serial transmit timing
    // ========================================================================
    // 50 MHz / 115200 baud
    localparam int clks_per_bit = 434;
    localparam int tx_timer_w = $clog2(clks_per_bit);

    // Start, 8 data, stop
    localparam int tx_frame_bits = 10;
    localparam int tx_cnt_w = $clog2(tx_frame_bits);

    // Line level between frames
    localparam logic tx_idle_level = 1'b1;

endpackage

// ==== common/mem_if.sv ====
`timescale 1ns/1ns

interface mem_if import soc_map_pkg::*; ();

    // Access strobe, write when we is also high
    logic en;
    logic we;
    // Word index into the RAM
    logic [ram_addr_w-1:0] addr;
    logic [data_w-1:0] wdata;
    // Registered read data, valid the cycle after en
    logic [data_w-1:0] rdata;

    // Bus side drives the request
    modport ctrl (
        output en,
        output we,
        output addr,
        output wdata,
        input  rdata
    );

    // Array side answers it
    modport mem (
        input  en,
        input  we,
        input  addr,
        input  wdata,
        output rdata
    );

endinterface

// ==== bus/scratch_ram.sv ====
`timescale 1ns/1ns

module scratch_ram import soc_map_pkg::*; (
    input logic CLOCK_50,
    mem_if.mem  port
);

    // ========================================================================
    // Block RAM array
    // ========================================================================
    logic [data_w-1:0] mem_array [ram_words];

    // Single port with write priority over read
    always_ff @(posedge CLOCK_50) begin
        if (port.en) begin
            if (port.we) begin
                mem_array[port.addr] <= port.wdata;
            end else begin
                // Registered read with one cycle of latency
                port.rdata <= mem_array[port.addr];
            end
        end
    end

endmodule

// ==== bus/bus_decoder.sv ====
`timescale 1ns/1ns

module bus_decoder import soc_map_pkg::*; (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    // Wishbone classic slave
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [addr_w-1:0] wb_adr,
    input  logic [data_w-1:0] wb_dat_w,
    output logic [data_w-1:0] wb_dat_r,
    output logic              wb_ack,
    // Scratch RAM port
    mem_if.ctrl               ram,
    // Keyboard side
    input  logic [7:0]        key_code,
    input  logic              key_strobe,
    // Serial side
    output logic [7:0]        tx_byte,
    output logic              tx_start,
    input  logic              tx_busy,
    // Board outputs
    output logic              irq,
    output logic [7:0]        ledg
);

    bus_target_t target;
    bus_target_t target_q;

    logic req;
    logic tx_hold;
    logic accept;
    logic rd_accept;
    logic wr_accept;

    logic [7:0]        key_code_q;
    logic              key_valid;
    logic              irq_pending;
    logic [data_w-1:0] rd_data_q;

    // ========================================================================
    // Address decode
    // ========================================================================
    always_comb begin
        target = tgt_none;
        if (wb_adr < ram_top) begin
            target = tgt_ram;
        end else begin
            case (wb_adr)
                key_data_addr:   target = tgt_key_data;
                key_status_addr: target = tgt_key_status;
                tx_data_addr:    target = tgt_tx_data;
                tx_status_addr:  target = tgt_tx_status;
                irq_addr:        target = tgt_irq;
                default:         target = tgt_none;
            endcase
        end
    end

    // Open request, no ack issued for it yet
    assign req = wb_cyc & wb_stb & ~wb_ack;
    // Transmit write waits while a frame is on the line
    assign tx_hold = (target == tgt_tx_data) & wb_we & tx_busy;
    assign accept = req & ~tx_hold;
    assign rd_accept = accept & ~wb_we;
    assign wr_accept = accept & wb_we;

    // RAM sees the request on the sampling edge, data comes back with ack
    assign ram.en = req & (target == tgt_ram);
    assign ram.we = wb_we;
    assign ram.addr = wb_adr[ram_addr_w+1:2];
    assign ram.wdata = wb_dat_w;

    // ========================================================================
    // Ack, transmit launch and status flags
    // ========================================================================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            wb_ack <= 1'b0;
            tx_start <= 1'b0;
            target_q <= tgt_none;
            key_code_q <= 8'd0;
            key_valid <= 1'b0;
            irq_pending <= 1'b0;
        end else begin
            wb_ack <= accept;
            // Launch lands in the same cycle as the ack
            tx_start <= wr_accept & (target == tgt_tx_data);
            if (accept) begin
                target_q <= target;
            end
            if (key_strobe) begin
                key_code_q <= key_code;
            end
            // New code wins over the clearing read
            if (key_strobe) begin
                key_valid <= 1'b1;
            end else if (rd_accept && target == tgt_key_data) begin
                key_valid <= 1'b0;
            end
            // Likewise for the interrupt clear
            if (key_strobe) begin
                irq_pending <= 1'b1;
            end else if (wr_accept && target == tgt_irq) begin
                irq_pending <= 1'b0;
            end
        end
    end

    // Register read data and transmit byte
    always_ff @(posedge CLOCK_50) begin
        if (accept) begin
            case (target)
                tgt_key_data:   rd_data_q <= {24'd0, key_code_q};
                tgt_key_status: rd_data_q <= {31'd0, key_valid};
                tgt_tx_status:  rd_data_q <= {31'd0, tx_busy};
                tgt_irq:        rd_data_q <= {31'd0, irq_pending};
                default:        rd_data_q <= '0;
            endcase
        end
        if (wr_accept && target == tgt_tx_data) begin
            tx_byte <= wb_dat_w[7:0];
        end
    end

    // RAM data arrives straight from the array in the ack cycle
    assign wb_dat_r = (target_q == tgt_ram) ? ram.rdata : rd_data_q;

    assign irq = irq_pending;
    assign ledg = key_code_q;

    // ========================================================================
    // Checks
    // ========================================================================
    // Master must still hold the strobe when ack shows up
    ack_needs_stb: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0) wb_ack |-> (wb_cyc && wb_stb)
    );

    // Launch only reaches an idle transmitter
    start_while_idle: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0) tx_start |-> !tx_busy
    );

endmodule

// ==== verilog/ps2_receiver.sv ====
`timescale 1ns/1ns

module ps2_receiver import periph_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] code,
    output logic       code_valid
);

    logic [2:0]                clk_sync;
    logic [1:0]                dat_sync;
    logic                      clk_fall;
    logic [ps2_frame_bits-1:0] frame;
    logic [ps2_cnt_w-1:0]      bit_cnt;
    logic                      frame_done;
    logic                      frame_ok;
    logic [7:0]                frame_byte;
    logic                      break_seen;

    // ========================================================================
    // Synchronizers and edge detect
    // ========================================================================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            // Both lines idle high
            clk_sync <= '1;
            dat_sync <= '1;
        end else begin
            clk_sync <= {clk_sync[1:0], ps2_clk};
            dat_sync <= {dat_sync[0], ps2_dat};
        end
    end

    // Device changes data on the rising edge, sample on the falling one
    assign clk_fall = clk_sync[2] & ~clk_sync[1];

    // ========================================================================
    // Frame assembly
    // ========================================================================
    // Bits arrive LSB first, start bit ends up in bit 0
    always_ff @(posedge CLOCK_50) begin
        if (clk_fall) begin
            frame <= {dat_sync[1], frame[ps2_frame_bits-1:1]};
        end
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            bit_cnt <= '0;
            frame_done <= 1'b0;
        end else begin
            frame_done <= 1'b0;
            if (clk_fall) begin
                if (bit_cnt == ps2_cnt_w'(ps2_frame_bits - 1)) begin
                    bit_cnt <= '0;
                    frame_done <= 1'b1;
                end else begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    assign frame_byte = frame[8:1];
    // Start low, stop high, odd count of ones over data and parity
    assign frame_ok = ~frame[0] & frame[10] & (^frame[9:1]);

    // ========================================================================
    // Break filter and output strobe
    // ========================================================================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            break_seen <= 1'b0;
            code_valid <= 1'b0;
        end else begin
            code_valid <= 1'b0;
            if (frame_done && frame_ok) begin
                if (frame_byte == ps2_break_code) begin
                    break_seen <= 1'b1;
                end else if (break_seen) begin
                    // Released key, swallow it
                    break_seen <= 1'b0;
                end else begin
                    code_valid <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (frame_done && frame_ok && !break_seen && frame_byte != ps2_break_code) begin
            code <= frame_byte;
        end
    end

endmodule

// ==== verilog/serial_tx.sv ====
`timescale 1ns/1ns

module serial_tx import periph_pkg::*; (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic [7:0] data,
    input  logic       start,
    output logic       txd,
    output logic       busy
);

    logic [tx_frame_bits-1:0] shifter;
    logic [tx_timer_w-1:0]    bit_timer;
    logic [tx_cnt_w-1:0]      bit_cnt;
    logic                     bit_end;

    assign bit_end = (bit_timer == tx_timer_w'(clks_per_bit - 1));

    // ========================================================================
    // Frame shifter
    // ========================================================================
    // Stop, data, start with the start bit leaving first
    always_ff @(posedge CLOCK_50) begin
        if (!busy && start) begin
            shifter <= {1'b1, data, 1'b0};
        end else if (busy && bit_end) begin
            shifter <= {1'b1, shifter[tx_frame_bits-1:1]};
        end
    end

    // ========================================================================
    // Bit timing and line control
    // ========================================================================
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            busy <= 1'b0;
            txd <= tx_idle_level;
            bit_timer <= '0;
            bit_cnt <= '0;
        end else if (!busy) begin
            txd <= tx_idle_level;
            if (start) begin
                busy <= 1'b1;
                txd <= 1'b0;
                bit_timer <= '0;
                bit_cnt <= '0;
            end
        end else if (bit_end) begin
            bit_timer <= '0;
            if (bit_cnt == tx_cnt_w'(tx_frame_bits - 1)) begin
                // Stop bit done, back to idle
                busy <= 1'b0;
                txd <= tx_idle_level;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
                txd <= shifter[1];
            end
        end else begin
            bit_timer <= bit_timer + 1'b1;
        end
    end

    // Launch only while idle
    start_when_idle: assert property (
        @(posedge CLOCK_50) disable iff (!KEY0) start |-> !busy
    );

endmodule

// ==== verilog/board_bus_top.sv ====
`timescale 1ns/1ns

module board_bus_top import soc_map_pkg::*; (
    input  logic              CLOCK_50,
    input  logic              KEY0,
    // Wishbone slave
    input  logic              wb_cyc,
    input  logic              wb_stb,
    input  logic              wb_we,
    input  logic [addr_w-1:0] wb_adr,
    input  logic [data_w-1:0] wb_dat_w,
    output logic [data_w-1:0] wb_dat_r,
    output logic              wb_ack,
    // Keyboard port
    input  logic              ps2_clk,
    input  logic              ps2_dat,
    // Serial line
    output logic              uart_txd,
    output logic              irq,
    output logic [7:0]        ledg
);

    logic [7:0] key_code;
    logic       key_strobe;
    logic [7:0] tx_byte;
    logic       tx_start;
    logic       tx_busy;

    mem_if ram_port ();

    // ========================================================================
    // Input side
    // ========================================================================
    ps2_receiver ps2_receiver_inst (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .code       (key_code),
        .code_valid (key_strobe)
    );

    // ========================================================================
    // Bus decoder and RAM
    // ========================================================================
    bus_decoder bus_decoder_inst (
        .CLOCK_50   (CLOCK_50),
        .KEY0       (KEY0),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .ram        (ram_port.ctrl),
        .key_code   (key_code),
        .key_strobe (key_strobe),
        .tx_byte    (tx_byte),
        .tx_start   (tx_start),
        .tx_busy    (tx_busy),
        .irq        (irq),
        .ledg       (ledg)
    );

    scratch_ram scratch_ram_inst (
        .CLOCK_50 (CLOCK_50),
        .port     (ram_port.mem)
    );

    // ========================================================================
    // Output side
    // ========================================================================
    serial_tx serial_tx_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .data     (tx_byte),
        .start    (tx_start),
        .txd      (uart_txd),
        .busy     (tx_busy)
    );

endmodule

// ==== bench/tb_board_bus.sv ====
`timescale 1ns/1ns

module tb_board_bus import soc_map_pkg::*, periph_pkg::*; ();

    // ========================================================================
    // Bench limits
    // ========================================================================
    // Longest hold-off is one full serial frame
    localparam int bus_timeout = 12 * clks_per_bit;
    // Room for two frames back to back
    localparam int line_timeout = 24 * clks_per_bit;
    // Half of the 2000 ns PS/2 clock period
    localparam int ps2_half = 125;

    logic              CLOCK_50;
    logic              KEY0;
    logic              wb_cyc;
    logic              wb_stb;
    logic              wb_we;
    logic [addr_w-1:0] wb_adr;
    logic [data_w-1:0] wb_dat_w;
    logic [data_w-1:0] wb_dat_r;
    logic              wb_ack;
    logic              ps2_clk;
    logic              ps2_dat;
    logic              uart_txd;
    logic              irq;
    logic [7:0]        ledg;

    integer seed;
    int     errors;
    int     checks;

    board_bus_top board_bus_top_inst (
        .CLOCK_50 (CLOCK_50),
        .KEY0     (KEY0),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .ps2_clk  (ps2_clk),
        .ps2_dat  (ps2_dat),
        .uart_txd (uart_txd),
        .irq      (irq),
        .ledg     (ledg)
    );

    // 125 MHz bench clock
    initial begin
        CLOCK_50 = 1'b0;
        forever #4 CLOCK_50 = ~CLOCK_50;
    end

    // ========================================================================
    // Check and report helpers
    // ========================================================================
    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s expected %h got %h", $time, name, exp, got);
        end
    endtask

    task automatic report_problem(input string what);
        checks++;
        errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    task automatic close_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - errors_before);
        end
    endtask

    // Address map as seen by the master
    function automatic logic [addr_w-1:0] register_address(input bus_target_t t);
        case (t)
            tgt_key_data:   return key_data_addr;
            tgt_key_status: return key_status_addr;
            tgt_tx_data:    return tx_data_addr;
            tgt_tx_status:  return tx_status_addr;
            tgt_irq:        return irq_addr;
            // Hole in the map
            tgt_none:       return 16'h3000;
            default:        return 16'h0000;
        endcase
    endfunction

    // ========================================================================
    // Wishbone master model
    // ========================================================================
    // lat counts cycles from the first sampling edge to the ack cycle
    task automatic bus_cycle(input logic we, input logic [addr_w-1:0] adr,
                             input logic [data_w-1:0] wdata,
                             output logic [data_w-1:0] rdata, output int lat);
        int cnt;
        @(posedge CLOCK_50);
        wb_cyc <= 1'b1;
        wb_stb <= 1'b1;
        wb_we <= we;
        wb_adr <= adr;
        wb_dat_w <= wdata;
        // Edge that first samples stb
        @(posedge CLOCK_50);
        cnt = 0;
        lat = -1;
        rdata = '0;
        while (lat < 0 && cnt < bus_timeout) begin
            @(negedge CLOCK_50);
            cnt++;
            if (wb_ack) begin
                lat = cnt;
                rdata = wb_dat_r;
            end
        end
        if (lat < 0) begin
            report_problem($sformatf("no ack for access at address %h", adr));
        end
        // Drop stb the cycle after ack
        @(posedge CLOCK_50);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we <= 1'b0;
    endtask

    task automatic wb_write(input logic [addr_w-1:0] adr, input logic [data_w-1:0] data,
                            output int lat);
        logic [data_w-1:0] unused;
        bus_cycle(1'b1, adr, data, unused, lat);
    endtask

    task automatic wb_read(input logic [addr_w-1:0] adr, output logic [data_w-1:0] data,
                           output int lat);
        bus_cycle(1'b0, adr, '0, data, lat);
    endtask

    // ========================================================================
    // PS/2 device and serial line models
    // ========================================================================
    // Data changes while the clock is high and the receiver samples on the fall
    task automatic ps2_send_byte(input logic [7:0] value, input logic bad_parity);
        logic [10:0] frame;
        frame = {1'b1, (~^value) ^ bad_parity, value, 1'b0};
        for (int i = 0; i < 11; i++) begin
            @(posedge CLOCK_50);
            ps2_dat <= frame[i];
            repeat (ps2_half) @(posedge CLOCK_50);
            ps2_clk <= 1'b0;
            repeat (ps2_half) @(posedge CLOCK_50);
            ps2_clk <= 1'b1;
        end
    endtask

    task automatic expect_serial_byte(input logic [7:0] expected);
        logic [7:0] got;
        int cnt;
        cnt = 0;
        while (uart_txd !== 1'b0 && cnt < line_timeout) begin
            @(negedge CLOCK_50);
            cnt++;
        end
        if (uart_txd !== 1'b0) begin
            report_problem("no start bit seen on uart_txd");
        end else begin
            // Middle of the start bit and then one bit time per step
            repeat (clks_per_bit / 2) @(negedge CLOCK_50);
            compare_value("uart_txd start bit", uart_txd, 0);
            for (int i = 0; i < 8; i++) begin
                repeat (clks_per_bit) @(negedge CLOCK_50);
                got[i] = uart_txd;
            end
            compare_value("uart_txd data", got, expected);
            repeat (clks_per_bit) @(negedge CLOCK_50);
            compare_value("uart_txd stop bit", uart_txd, 1);
        end
    endtask

    // ========================================================================
    // Directed tests
    // ========================================================================
    task automatic check_reset();
        int err0;
        int lat;
        logic [data_w-1:0] rd;
        err0 = errors;
        @(negedge CLOCK_50);
        compare_value("irq", irq, 0);
        compare_value("wb_ack", wb_ack, 0);
        compare_value("uart_txd", uart_txd, 1);
        compare_value("ledg", ledg, 0);
        wb_read(register_address(tgt_key_status), rd, lat);
        compare_value("key_status", rd, 0);
        wb_read(register_address(tgt_irq), rd, lat);
        compare_value("irq_pending", rd, 0);
        close_test("reset", err0);
    endtask

    task automatic ram_readback();
        int err0;
        int lat;
        logic dup;
        logic [data_w-1:0] rd;
        logic [ram_addr_w-1:0] idx [16];
        logic [data_w-1:0] val [16];
        err0 = errors;
        for (int i = 0; i < 16; i++) begin
            // Word indices must not repeat
            do begin
                idx[i] = $random(seed);
                dup = 1'b0;
                for (int j = 0; j < i; j++) begin
                    if (idx[j] == idx[i]) begin
                        dup = 1'b1;
                    end
                end
            end while (dup);
            val[i] = $random(seed);
            wb_write({4'h0, idx[i], 2'b00}, val[i], lat);
            compare_value("ram write ack latency", lat, 1);
        end
        for (int i = 0; i < 16; i++) begin
            wb_read({4'h0, idx[i], 2'b00}, rd, lat);
            compare_value("ram read ack latency", lat, 1);
            compare_value("ram wb_dat_r", rd, val[i]);
        end
        // Unmapped hole acks and reads zero
        wb_write(register_address(tgt_none), 32'hdead_beef, lat);
        compare_value("unmapped write ack latency", lat, 1);
        wb_read(register_address(tgt_none), rd, lat);
        compare_value("unmapped read ack latency", lat, 1);
        compare_value("unmapped wb_dat_r", rd, 0);
        close_test("ram", err0);
    endtask

    task automatic keyboard_irq();
        int err0;
        int lat;
        int cnt;
        logic [data_w-1:0] rd;
        err0 = errors;
        ps2_send_byte(8'h1c, 1'b0);
        cnt = 0;
        while (!irq && cnt < 64) begin
            @(negedge CLOCK_50);
            cnt++;
        end
        compare_value("irq", irq, 1);
        compare_value("ledg", ledg, 8'h1c);
        wb_read(register_address(tgt_key_status), rd, lat);
        compare_value("key_status", rd, 1);
        wb_read(register_address(tgt_key_data), rd, lat);
        compare_value("key_data", rd, 8'h1c);
        // Data read consumed the code
        wb_read(register_address(tgt_key_status), rd, lat);
        compare_value("key_status after read", rd, 0);
        @(negedge CLOCK_50);
        compare_value("irq before clear", irq, 1);
        wb_write(register_address(tgt_irq), 32'h0, lat);
        @(negedge CLOCK_50);
        compare_value("irq after clear", irq, 0);
        close_test("keyboard", err0);
    endtask

    task automatic dropped_frames();
        int err0;
        int lat;
        logic [data_w-1:0] rd;
        err0 = errors;
        ps2_send_byte(8'h23, 1'b1);
        // Key release so neither byte may come out
        ps2_send_byte(ps2_break_code, 1'b0);
        ps2_send_byte(8'h2b, 1'b0);
        repeat (16) @(negedge CLOCK_50);
        compare_value("irq", irq, 0);
        compare_value("ledg", ledg, 8'h1c);
        wb_read(register_address(tgt_key_status), rd, lat);
        compare_value("key_status", rd, 0);
        close_test("dropped frames", err0);
    endtask

    task automatic serial_output();
        int err0;
        int lat;
        int cnt;
        logic [7:0] tx_val;
        logic [data_w-1:0] rd;
        err0 = errors;
        tx_val = $random(seed);
        wb_write(register_address(tgt_tx_data), {24'd0, tx_val}, lat);
        compare_value("tx_data ack latency", lat, 1);
        fork
            expect_serial_byte(tx_val);
            begin
                // Well inside the data bits
                repeat (3 * clks_per_bit) @(negedge CLOCK_50);
                wb_read(register_address(tgt_tx_status), rd, lat);
                compare_value("tx_status during frame", rd, 1);
            end
        join
        // Rest of the stop bit
        cnt = 0;
        rd = 32'd1;
        while (rd[0] && cnt < clks_per_bit) begin
            wb_read(register_address(tgt_tx_status), rd, lat);
            cnt++;
        end
        if (rd[0]) begin
            report_problem("serial_tx still busy long after the stop bit");
        end
        close_test("serial output", err0);
    endtask

    task automatic tx_back_pressure();
        int err0;
        int lat_a;
        int lat_b;
        logic [7:0] byte_a;
        logic [7:0] byte_b;
        err0 = errors;
        byte_a = $random(seed);
        byte_b = $random(seed);
        wb_write(register_address(tgt_tx_data), {24'd0, byte_a}, lat_a);
        compare_value("first tx_data ack latency", lat_a, 1);
        fork
            expect_serial_byte(byte_a);
            wb_write(register_address(tgt_tx_data), {24'd0, byte_b}, lat_b);
        join
        // Second ack held until the whole first frame has gone
        // Busy spans ten bit times from the edge the second access is first sampled on
        compare_value("second tx_data ack latency", lat_b, 10 * clks_per_bit);
        expect_serial_byte(byte_b);
        close_test("back-pressure", err0);
    endtask

    // ========================================================================
    // Sequence
    // ========================================================================
    initial begin
        seed = 32'hb6c2;
        errors = 0;
        checks = 0;
        KEY0 = 1'b0;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        ps2_clk = 1'b1;
        ps2_dat = 1'b1;
        repeat (4) @(posedge CLOCK_50);
        KEY0 <= 1'b1;

        check_reset();
        ram_readback();
        keyboard_irq();
        dropped_frames();
        serial_output();
        tx_back_pressure();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== compile.f ====
common/soc_map_pkg.sv
common/periph_pkg.sv
common/mem_if.sv
bus/scratch_ram.sv
bus/bus_decoder.sv
verilog/ps2_receiver.sv
verilog/serial_tx.sv
verilog/board_bus_top.sv
bench/tb_board_bus.sv

// ==== Bender.yml ====
package:
  name: board_bus

sources:
  - files:
      - common/soc_map_pkg.sv
      - common/periph_pkg.sv
      - common/mem_if.sv
      - bus/scratch_ram.sv
      - bus/bus_decoder.sv
      - verilog/ps2_receiver.sv
      - verilog/serial_tx.sv
      - verilog/board_bus_top.sv
  - target: simulation
    files:
      - bench/tb_board_bus.sv
